// ==== hw/memctl_pkg.sv ====
package memctl_pkg;

  // bus geometry
  localparam int xlen      = 32;
  localparam int byte_amnt = xlen / 8;

  // ram banks, one per 16 MiB region
  localparam int ram_banks = 4;
  localparam int ram_words = 256;                 // higher offsets alias
  localparam int ram_aw    = $clog2(ram_words);
  localparam int bank_iw   = $clog2(ram_banks);

  // top address byte of each region
  localparam logic [7:0] rom_byte       = 8'h00;
  localparam logic [7:0] ram_first_byte = 8'h01;
  localparam logic [7:0] ram_last_byte  = ram_first_byte + 8'(ram_banks - 1);

  // machine timer registers, 8 byte aligned pairs
  localparam logic [xlen-1:0] msip_addr     = 32'hFFFF_FFC0;
  localparam logic [xlen-1:0] mtime_addr    = 32'hFFFF_FFE0; // high word at +4
  localparam logic [xlen-1:0] mtimecmp_addr = 32'hFFFF_FFF0; // high word at +4

  // timer register selector
  localparam logic [1:0] csr_sel_msip     = 2'b00;
  localparam logic [1:0] csr_sel_mtime    = 2'b10;
  localparam logic [1:0] csr_sel_mtimecmp = 2'b11;

  // which target owns the current access
  typedef enum logic [2:0] {
    tgt_none = 3'd0,  // unmapped, answered with err
    tgt_rom  = 3'd1,
    tgt_ram  = 3'd2,
    tgt_csr  = 3'd3
  } target_t;

endpackage

// ==== hw/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder
  import memctl_pkg::*;
(
  input  logic                 cyc,
  input  logic                 we,
  input  logic [byte_amnt-1:0] sel,
  input  logic [xlen-1:0]      adr,
  input  logic [xlen-1:0]      wdat,
  output target_t              target,
  output logic [ram_banks-1:0] bank_stb,
  output logic [ram_aw-1:0]    bank_adr,
  output logic                 rom_cyc,
  output logic [xlen-1:0]      rom_adr,
  output logic                 csr_stb,
  output logic [1:0]           csr_sel,
  output logic                 csr_hi,
  output logic                 t_we,
  output logic [byte_amnt-1:0] t_sel,
  output logic [xlen-1:0]      t_wdat
);

  logic [7:0] top_byte;
  logic [7:0] bank_off;
  logic       rom_hit;
  logic       ram_hit;
  logic       msip_hit;
  logic       mtime_hit;
  logic       mtimecmp_hit;
  logic       local_tgt;

  assign top_byte = adr[xlen-1:xlen-8];
  assign bank_off = top_byte - ram_first_byte;  // region 0x01 is bank 0

  assign rom_hit = (top_byte == rom_byte);
  assign ram_hit = (top_byte >= ram_first_byte) && (top_byte <= ram_last_byte);

  // exact word match, bit 2 picks the half of the 64-bit pair
  assign msip_hit     = (adr == msip_addr);
  assign mtime_hit    = (adr[xlen-1:3] == mtime_addr[xlen-1:3]) && (adr[1:0] == 2'b00);
  assign mtimecmp_hit = (adr[xlen-1:3] == mtimecmp_addr[xlen-1:3]) && (adr[1:0] == 2'b00);

  always_comb begin
    if (rom_hit) begin
      target = tgt_rom;
    end else if (ram_hit) begin
      target = tgt_ram;
    end else if (msip_hit || mtime_hit || mtimecmp_hit) begin
      target = tgt_csr;
    end else begin
      target = tgt_none;
    end
  end

  always_comb begin
    csr_sel = csr_sel_msip;
    if (mtime_hit) begin
      csr_sel = csr_sel_mtime;
    end else if (mtimecmp_hit) begin
      csr_sel = csr_sel_mtimecmp;
    end
  end
  assign csr_hi = adr[2];

  always_comb begin
    for (int i = 0; i < ram_banks; i++) begin
      bank_stb[i] = cyc && (target == tgt_ram) && (bank_off[bank_iw-1:0] == bank_iw'(i));
    end
  end
  assign bank_adr = adr[ram_aw+1:2];  // word index, upper offset bits alias

  // external rom sees only its 16 MiB window
  assign rom_cyc = cyc && (target == tgt_rom);
  assign rom_adr = {8'h00, adr[23:0]};

  assign csr_stb = cyc && (target == tgt_csr);

  // only ram and timer take writes
  assign local_tgt = (target == tgt_ram) || (target == tgt_csr);
  assign t_we      = cyc && we && local_tgt;
  assign t_sel     = local_tgt ? sel : '0;
  assign t_wdat    = wdat;

endmodule

// ==== hw/ram_bank.sv ====
`timescale 1ns/1ps

module ram_bank
  import memctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stb,
  input  logic                 we,
  input  logic [byte_amnt-1:0] sel,
  input  logic [ram_aw-1:0]    adr,
  input  logic [xlen-1:0]      wdat,
  output logic                 ack,
  output logic [xlen-1:0]      rdat
);

  logic [xlen-1:0] mem [ram_words];
  logic            access;

  // new access only when the last ack has dropped
  assign access = stb && !ack;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // byte lane writes
  always_ff @(posedge clk) begin
    if (access && we) begin
      for (int b = 0; b < byte_amnt; b++) begin
        if (sel[b]) begin
          mem[adr][8*b +: 8] <= wdat[8*b +: 8];
        end
      end
    end
  end

  // registered read, old word on a write cycle
  always_ff @(posedge clk) begin
    if (access) begin
      rdat <= mem[adr];
    end
  end

endmodule

// ==== hw/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer
  import memctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stb,
  input  logic                 we,
  input  logic [byte_amnt-1:0] sel,
  input  logic [1:0]           csr_sel,
  input  logic                 csr_hi,
  input  logic [xlen-1:0]      wdat,
  output logic                 ack,
  output logic [xlen-1:0]      rdat,
  output logic                 timer_irq,
  output logic                 soft_irq
);

  logic [2*xlen-1:0] mtime;
  logic [2*xlen-1:0] mtimecmp;
  logic              msip;
  logic              access;
  logic              wr;

  // replace the enabled lanes of one 32-bit half
  function automatic logic [2*xlen-1:0] merge_half(input logic [2*xlen-1:0] old_val,
                                                   input logic hi,
                                                   input logic [xlen-1:0] data,
                                                   input logic [byte_amnt-1:0] lanes);
    logic [2*xlen-1:0] res;
    res = old_val;
    for (int b = 0; b < byte_amnt; b++) begin
      if (lanes[b]) begin
        res[(hi ? xlen : 0) + 8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign access = stb && !ack;
  assign wr     = access && we;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtime     <= '0;
      mtimecmp  <= '0;
      msip      <= 1'b0;
      timer_irq <= 1'b0;
    end else begin
      // a software write wins over the increment
      if (wr && csr_sel == csr_sel_mtime) begin
        mtime <= merge_half(mtime, csr_hi, wdat, sel);
      end else begin
        mtime <= mtime + 1'b1;
      end
      if (wr && csr_sel == csr_sel_mtimecmp) begin
        mtimecmp <= merge_half(mtimecmp, csr_hi, wdat, sel);
      end
      if (wr && csr_sel == csr_sel_msip && sel[0]) begin
        msip <= wdat[0];
      end
      timer_irq <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (csr_sel)
        csr_sel_msip:     rdat <= {{(xlen-1){1'b0}}, msip};
        csr_sel_mtime:    rdat <= csr_hi ? mtime[2*xlen-1:xlen] : mtime[xlen-1:0];
        csr_sel_mtimecmp: rdat <= csr_hi ? mtimecmp[2*xlen-1:xlen] : mtimecmp[xlen-1:0];
        default:          rdat <= '0;
      endcase
    end
  end

  assign soft_irq = msip;

endmodule

// ==== hw/response_mux.sv ====
`timescale 1ns/1ps

module response_mux
  import memctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cyc,
  input  target_t              target,
  input  logic                 rom_ack,
  input  logic [xlen-1:0]      rom_dat,
  input  logic [ram_banks-1:0] bank_ack,
  input  logic [xlen-1:0]      bank_dat [ram_banks],
  input  logic                 csr_ack,
  input  logic [xlen-1:0]      csr_dat,
  output logic                 ack,
  output logic                 err,
  output logic [xlen-1:0]      rdat
);

  logic            err_q;
  logic [xlen-1:0] bank_rdat;

  // one-cycle error ack for unmapped accesses, no repeat while high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= cyc && (target == tgt_none) && !err_q;
    end
  end

  // only the acknowledging bank drives data
  always_comb begin
    bank_rdat = '0;
    for (int i = 0; i < ram_banks; i++) begin
      if (bank_ack[i]) begin
        bank_rdat = bank_dat[i];
      end
    end
  end

  assign err = err_q;

  always_comb begin
    case (target)
      tgt_rom: begin
        ack  = rom_ack;   // rom latency passes straight through
        rdat = rom_dat;
      end
      tgt_ram: begin
        ack  = |bank_ack;
        rdat = bank_rdat;
      end
      tgt_csr: begin
        ack  = csr_ack;
        rdat = csr_dat;
      end
      default: begin
        ack  = err;
        rdat = '0;        // unmapped reads return zero
      end
    endcase
  end

endmodule

// ==== hw/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top
  import memctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  // processor port
  input  logic                 cyc,
  input  logic                 we,
  input  logic [byte_amnt-1:0] sel,
  input  logic [xlen-1:0]      adr,
  input  logic [xlen-1:0]      wdat,
  output logic                 ack,
  output logic                 err,
  output logic [xlen-1:0]      rdat,
  // external instruction cache / rom
  output logic                 rom_cyc,
  output logic [xlen-1:0]      rom_adr,
  input  logic                 rom_ack,
  input  logic [xlen-1:0]      rom_dat,
  // interrupts
  output logic                 timer_irq,
  output logic                 soft_irq
);

  target_t              target;
  logic [ram_banks-1:0] bank_stb;
  logic [ram_aw-1:0]    bank_adr;
  logic                 csr_stb;
  logic [1:0]           csr_sel;
  logic                 csr_hi;
  logic                 t_we;
  logic [byte_amnt-1:0] t_sel;
  logic [xlen-1:0]      t_wdat;
  wire  [ram_banks-1:0] bank_ack;
  wire  [xlen-1:0]      bank_dat [ram_banks];
  logic                 csr_ack;
  logic [xlen-1:0]      csr_dat;

  bus_decoder u_decoder (
    .cyc      (cyc),
    .we       (we),
    .sel      (sel),
    .adr      (adr),
    .wdat     (wdat),
    .target   (target),
    .bank_stb (bank_stb),
    .bank_adr (bank_adr),
    .rom_cyc  (rom_cyc),
    .rom_adr  (rom_adr),
    .csr_stb  (csr_stb),
    .csr_sel  (csr_sel),
    .csr_hi   (csr_hi),
    .t_we     (t_we),
    .t_sel    (t_sel),
    .t_wdat   (t_wdat)
  );

  // one bank per ram region
  for (genvar i = 0; i < ram_banks; i++) begin : g_bank
    ram_bank u_bank (
      .clk    (clk),
      .arst_n (arst_n),
      .stb    (bank_stb[i]),
      .we     (t_we),
      .sel    (t_sel),
      .adr    (bank_adr),
      .wdat   (t_wdat),
      .ack    (bank_ack[i]),
      .rdat   (bank_dat[i])
    );
  end

  csr_timer u_timer (
    .clk       (clk),
    .arst_n    (arst_n),
    .stb       (csr_stb),
    .we        (t_we),
    .sel       (t_sel),
    .csr_sel   (csr_sel),
    .csr_hi    (csr_hi),
    .wdat      (t_wdat),
    .ack       (csr_ack),
    .rdat      (csr_dat),
    .timer_irq (timer_irq),
    .soft_irq  (soft_irq)
  );

  response_mux u_resp (
    .clk      (clk),
    .arst_n   (arst_n),
    .cyc      (cyc),
    .target   (target),
    .rom_ack  (rom_ack),
    .rom_dat  (rom_dat),
    .bank_ack (bank_ack),
    .bank_dat (bank_dat),
    .csr_ack  (csr_ack),
    .csr_dat  (csr_dat),
    .ack      (ack),
    .err      (err),
    .rdat     (rdat)
  );

endmodule

// ==== verification/mem_subsystem_asserts.sv ====
`timescale 1ns/1ps

module mem_subsystem_asserts
  import memctl_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cyc,
  input  target_t              target,
  input  logic [ram_banks-1:0] bank_ack,
  input  logic                 ack,
  input  logic                 err,
  input  logic [xlen-1:0]      rdat
);

  int assert_fails = 0;  // read by the testbench

  // every acknowledge is a single-cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
    else begin
      $error("ack stayed high for two cycles");
      assert_fails++;
    end

  // no acknowledge outside a bus cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) ack |-> cyc)
    else begin
      $error("ack raised while cyc was low");
      assert_fails++;
    end

  err_zero_data: assert property (@(posedge clk) disable iff (!arst_n) err |-> (rdat == '0))
    else begin
      $error("err came with nonzero rdat");
      assert_fails++;
    end

  err_unmapped: assert property (@(posedge clk) disable iff (!arst_n) err |-> (target == tgt_none))
    else begin
      $error("err raised for a mapped target");
      assert_fails++;
    end

  // exactly one bank answers a ram access
  bank_onehot: assert property (@(posedge clk) disable iff (!arst_n)
                                (ack && target == tgt_ram) |-> $onehot(bank_ack))
    else begin
      $error("ram ack without exactly one bank ack");
      assert_fails++;
    end

endmodule

bind response_mux mem_subsystem_asserts u_asserts (
  .clk      (clk),
  .arst_n   (arst_n),
  .cyc      (cyc),
  .target   (target),
  .bank_ack (bank_ack),
  .ack      (ack),
  .err      (err),
  .rdat     (rdat)
);

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

  localparam int          timeout_cycles = 200;
  localparam int          rom_max_lat    = 4;
  localparam logic [31:0] rom_key        = 32'hC0DE_0000;
  localparam logic [31:0] msip_a         = 32'hFFFF_FFC0;
  localparam logic [31:0] mtime_a        = 32'hFFFF_FFE0;
  localparam logic [31:0] mtimecmp_a     = 32'hFFFF_FFF0;
  localparam logic [31:0] unmapped_a     = 32'h8000_0000;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        cyc;
  logic        we;
  logic [3:0]  sel;
  logic [31:0] adr;
  logic [31:0] wdat;
  logic        ack;
  logic        err;
  logic [31:0] rdat;
  logic        rom_cyc;
  logic [31:0] rom_adr;
  logic        rom_ack = 1'b0;
  logic [31:0] rom_dat = '0;
  logic        timer_irq;
  logic        soft_irq;

  int          seed     = 32'h5a75;
  int          rom_seed = 32'h5a75;  // separate stream for the rom model
  int          rom_left = 0;
  logic [31:0] ref_mem [4][256];     // mirror of the four banks
  logic [31:0] written_q [$];

  mem_subsystem_top dut (.*);

  always #10 clk = ~clk;

  // external rom, answers 1 to rom_max_lat cycles after rom_cyc
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rom_ack <= 1'b0;
      rom_left = 0;
    end else begin
      // rom cycle only while the processor accesses region 0x00
      assert (rom_cyc === (cyc && adr[31:24] == 8'h00))
        else mismatch($sformatf("rom_cyc %b for cyc %b at address %h", rom_cyc, cyc, adr));
      rom_ack <= 1'b0;
      if (rom_cyc && !rom_ack) begin
        if (rom_left == 0) begin
          rom_left = 1 + ($unsigned($random(rom_seed)) % rom_max_lat);
        end
        rom_left = rom_left - 1;
        if (rom_left == 0) begin
          rom_ack <= 1'b1;
          rom_dat <= rom_adr ^ rom_key;  // data follows the address
        end
      end
    end
  end

  always @(dut.u_resp.u_asserts.assert_fails) begin
    if (dut.u_resp.u_asserts.assert_fails != 0) begin
      fail_stop("a bound assertion on the bus handshake failed");
    end
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic mismatch(input string msg);
    fail_stop($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  // one access, lat counts cycles from cyc to ack
  task automatic bus_access(input logic w, input logic [3:0] s, input logic [31:0] a,
                            input logic [31:0] d, output logic [31:0] q, output logic e,
                            output int lat);
    int n;
    n = 0;
    @(posedge clk);
    cyc  <= 1'b1;
    we   <= w;
    sel  <= s;
    adr  <= a;
    wdat <= d;
    do begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) fail_stop("timeout: the DUT never acknowledged the access");
    end while (!ack);
    q   = rdat;
    e   = err;
    lat = n - 1;
    @(posedge clk);
    cyc <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] q;
    logic        e;
    int          lat;
    bus_access(1'b1, s, a, d, q, e, lat);
    assert (!e && lat == 1)
      else mismatch($sformatf("write %h: err %b after %0d cycles", a, e, lat));
    if (a[31:24] >= 8'h01 && a[31:24] <= 8'h04) begin
      for (int b = 0; b < 4; b++) begin
        if (s[b]) ref_mem[a[31:24] - 8'd1][a[9:2]][8*b +: 8] = d[8*b +: 8];
      end
      written_q.push_back(a);
    end
  endtask

  task automatic read_word(input logic [31:0] a, output logic [31:0] q);
    logic e;
    int   lat;
    bus_access(1'b0, 4'hF, a, '0, q, e, lat);
    assert (!e && lat == 1)
      else mismatch($sformatf("read %h: err %b after %0d cycles", a, e, lat));
  endtask

  task automatic read_ram_check(input logic [31:0] a);
    logic [31:0] q;
    logic [31:0] exp;
    read_word(a, q);
    exp = ref_mem[a[31:24] - 8'd1][a[9:2]];
    assert (q === exp) else mismatch($sformatf("ram %h read %h, expected %h", a, q, exp));
  endtask

  task automatic test_ram_rw();
    logic [31:0] a;
    for (int b = 0; b < 4; b++) begin
      repeat (4) begin
        a = {8'(b + 1), 14'h0, 8'($random(seed)), 2'b00};
        write_word(a, $random(seed), 4'hF);
      end
    end
    foreach (written_q[i]) read_ram_check(written_q[i]);
  endtask

  task automatic test_byte_sel();
    logic [31:0] a;
    logic [31:0] q;
    a = 32'h0300_0100;  // bank 2, word 0x40
    write_word(a, 32'h1122_3344, 4'hF);
    write_word(a, 32'hAABB_CCDD, 4'b0101);
    read_word(a, q);
    assert (q === 32'h11BB_33DD) else mismatch($sformatf("lanes 0 and 2 gave %h", q));
    repeat (8) begin
      write_word(a, $random(seed), 4'($random(seed)));
      read_ram_check(a);
    end
  endtask

  task automatic test_rom();
    logic [31:0] a;
    logic [31:0] q;
    logic        e;
    int          lat;
    repeat (8) begin
      a = {8'h00, 24'($random(seed))};
      bus_access(1'b0, 4'hF, a, '0, q, e, lat);
      assert (rom_adr === {8'h00, a[23:0]})
        else mismatch($sformatf("rom_adr %h for address %h", rom_adr, a));
      assert (!e && q === ({8'h00, a[23:0]} ^ rom_key))
        else mismatch($sformatf("rom read %h gave %h err %b", a, q, e));
      assert (lat >= 1 && lat <= rom_max_lat)
        else mismatch($sformatf("rom read %h took %0d cycles", a, lat));
    end
  endtask

  task automatic test_timer();
    logic [31:0] q;
    logic [31:0] t1;
    logic [31:0] t2;
    int          n;
    write_word(mtimecmp_a, 32'h1234_5678, 4'hF);
    write_word(mtimecmp_a + 32'd4, 32'h0000_00AB, 4'hF);
    write_word(mtimecmp_a, 32'h0000_EE00, 4'b0010);  // one lane only
    read_word(mtimecmp_a, q);
    assert (q === 32'h1234_EE78) else mismatch($sformatf("mtimecmp low %h", q));
    read_word(mtimecmp_a + 32'd4, q);
    assert (q === 32'h0000_00AB) else mismatch($sformatf("mtimecmp high %h", q));
    @(negedge clk);
    assert (timer_irq === 1'b0) else mismatch("timer_irq high with mtimecmp far ahead");
    read_word(mtime_a, t1);
    read_word(mtime_a, t2);
    assert (t2 > t1) else mismatch($sformatf("mtime went from %h to %h", t1, t2));
    // compare value a few dozen ticks ahead
    write_word(mtimecmp_a + 32'd4, 32'h0, 4'hF);
    write_word(mtimecmp_a, t2 + 32'd40, 4'hF);
    @(negedge clk);
    assert (timer_irq === 1'b0) else mismatch("timer_irq high before mtime reached mtimecmp");
    n = 0;
    while (!timer_irq) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) fail_stop("timeout: timer_irq did not rise after mtimecmp");
    end
    write_word(msip_a, 32'h1, 4'hF);
    @(negedge clk);
    assert (soft_irq === 1'b1) else mismatch("soft_irq low after msip set");
    read_word(msip_a, q);
    assert (q === 32'h1) else mismatch($sformatf("msip read %h", q));
    write_word(msip_a, 32'h0, 4'hF);
    @(negedge clk);
    assert (soft_irq === 1'b0) else mismatch("soft_irq high after msip cleared");
  endtask

  task automatic test_unmapped();
    logic [31:0] q;
    logic        e;
    int          lat;
    // word 0 of each bank is where the unmapped address would alias
    for (int b = 0; b < 4; b++) begin
      write_word({8'(b + 1), 24'h0}, $random(seed), 4'hF);
    end
    bus_access(1'b1, 4'hF, unmapped_a, 32'hDEAD_BEEF, q, e, lat);
    assert (e === 1'b1 && lat == 1)
      else mismatch($sformatf("unmapped write: err %b after %0d cycles", e, lat));
    bus_access(1'b0, 4'hF, unmapped_a, '0, q, e, lat);
    assert (e === 1'b1 && q === '0 && lat == 1)
      else mismatch($sformatf("unmapped read: err %b data %h after %0d cycles", e, q, lat));
    foreach (written_q[i]) read_ram_check(written_q[i]);  // ram untouched
  endtask

  initial begin
    arst_n = 1'b0;
    cyc    = 1'b0;
    we     = 1'b0;
    sel    = 4'h0;
    adr    = '0;
    wdat   = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    test_ram_rw();
    test_byte_sel();
    test_rom();
    test_timer();
    test_unmapped();
    repeat (2) @(posedge clk);
    if (dut.u_resp.u_asserts.assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("bound assertions failed %0d times", dut.u_resp.u_asserts.assert_fails);
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hw/memctl_pkg.sv
hw/bus_decoder.sv
hw/ram_bank.sv
hw/csr_timer.sv
hw/response_mux.sv
hw/mem_subsystem_top.sv
verification/mem_subsystem_asserts.sv
verification/mem_subsystem_tb.sv
